//--- all.f
rtl/procPkg.sv
rtl/pipeReg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/dataMem.sv
rtl/proc.sv
tb/proc_props.sv
tb/procTb.sv

//--- rtl/dataMem.sv
/*
 * Word-addressed data memory for the memory stage.
 * Stores write rtVal at aluOut on the clock edge, reads are combinational.
 * The whole array clears on reset so unwritten words read as zero.
 */
`timescale 1ns/100ps

module dataMem import procPkg::*; #(
    parameter int dmemDepth = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  exMemT            memIn,
    output logic [dataW-1:0] memOut
);

    localparam int dmemAW = $clog2(dmemDepth);

    logic [dataW-1:0]  mem [dmemDepth];
    logic [dmemAW-1:0] addr;

    assign addr = memIn.aluOut[dmemAW-1:0];  // Upper address bits ignored

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dmemDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (memIn.valid && memIn.memWrite) begin
            mem[addr] <= memIn.rtVal;
        end
    end

    assign memOut = mem[addr];

endmodule

//--- rtl/decode.sv
/*
 * Decode stage. Turns the fetched word into idEx controls, reads the
 * register file and extends immediates.
 * The register file writes before it reads, so only idEx and exMem
 * destinations can cause a stall. A stalled instruction sends a bubble.
 * halting flags a HALT in decode, err flags an unknown opcode.
 */
`timescale 1ns/100ps

module decode import procPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  ifIdT                idIn,
    input  idExT                exPeek,
    input  exMemT               memPeek,
    input  logic                wbEn,
    input  logic [regAddrW-1:0] wbAddr,
    input  logic [dataW-1:0]    wbData,
    output idExT                idOut,
    output logic                stall,
    output logic                halting,
    output logic                err
);

    localparam int numRegs = 2 ** regAddrW;

    logic [dataW-1:0]    regs [numRegs];
    opcodeT              opcode;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] rd;
    logic                readsRs;
    logic                readsRt;
    logic                illegal;
    idExT                dec;

    // Pending write to addr from an older instruction still in flight
    function automatic logic busy(input logic [regAddrW-1:0] addr,
                                  input idExT ex, input exMemT mem);
        logic exHit;
        logic memHit;
        exHit  = ex.valid && ex.regWrite && (ex.writeAddr == addr);
        memHit = mem.valid && mem.regWrite && (mem.writeAddr == addr);
        return exHit || memHit;
    endfunction

    assign opcode = opcodeT'(idIn.instr[15:11]);
    assign rs     = idIn.instr[10:8];
    assign rt     = idIn.instr[7:5];
    assign rd     = idIn.instr[4:2];

    // Register file, writeback port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_comb begin
        dec         = '0;
        dec.pc      = idIn.pc;
        dec.opcode  = opcode;
        dec.funct   = functT'(idIn.instr[1:0]);
        dec.rsVal   = (wbEn && wbAddr == rs) ? wbData : regs[rs];  // Write before read
        dec.rtVal   = (wbEn && wbAddr == rt) ? wbData : regs[rt];
        readsRs     = 1'b0;
        readsRt     = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            opAlu: begin
                dec.writeAddr = rd;
                dec.regWrite  = 1'b1;
                readsRs       = 1'b1;
                readsRt       = 1'b1;
            end
            opAddi: begin
                dec.immExt    = {{(dataW-5){idIn.instr[4]}}, idIn.instr[4:0]};
                dec.writeAddr = rt;
                dec.regWrite  = 1'b1;
                readsRs       = 1'b1;
            end
            opLbi: begin
                dec.immExt    = {{(dataW-8){idIn.instr[7]}}, idIn.instr[7:0]};
                dec.writeAddr = rs;               // Destination sits in rs slot
                dec.regWrite  = 1'b1;
            end
            opLd: begin
                dec.immExt    = {{(dataW-5){idIn.instr[4]}}, idIn.instr[4:0]};
                dec.writeAddr = rt;
                dec.regWrite  = 1'b1;
                dec.memRead   = 1'b1;
                readsRs       = 1'b1;
            end
            opSt: begin
                dec.immExt    = {{(dataW-5){idIn.instr[4]}}, idIn.instr[4:0]};
                dec.memWrite  = 1'b1;
                readsRs       = 1'b1;             // Base address
                readsRt       = 1'b1;             // Store data
            end
            opBeqz, opBnez: begin
                dec.immExt    = {{(dataW-8){idIn.instr[7]}}, idIn.instr[7:0]};
                dec.isBranch  = 1'b1;
                readsRs       = 1'b1;
            end
            opJ: begin
                dec.immExt    = {{(dataW-11){idIn.instr[10]}}, idIn.instr[10:0]};
                dec.isJump    = 1'b1;
            end
            opHalt: dec.halt = 1'b1;
            opNop:  ;                              // No side effects
            default: illegal = 1'b1;               // Passes down as a no-op
        endcase
    end

    // Interlock on either source still waiting for its producer
    assign stall = idIn.valid &&
                   ((readsRs && busy(rs, exPeek, memPeek)) ||
                    (readsRt && busy(rt, exPeek, memPeek)));

    always_comb begin
        idOut       = dec;
        idOut.valid = idIn.valid && !stall;  // Bubble while stalling
    end

    assign halting = idIn.valid && (opcode == opHalt);
    assign err     = idIn.valid && illegal;

endmodule

//--- rtl/execute.sv
/*
 * Execute stage, purely combinational.
 * Computes ALU, immediate, LBI and address results, and resolves
 * BEQZ, BNEZ and J. A taken branch or a jump pulses redirect with target.
 */
`timescale 1ns/100ps

module execute import procPkg::*; (
    input  idExT             exIn,
    output exMemT            exOut,
    output logic             redirect,
    output logic [dataW-1:0] target
);

    logic [dataW-1:0] aluOut;
    logic             rsZero;
    logic             taken;

    always_comb begin
        aluOut = '0;
        case (exIn.opcode)
            opAlu: begin
                case (exIn.funct)
                    fnAdd: aluOut = exIn.rsVal + exIn.rtVal;
                    fnSub: aluOut = exIn.rsVal - exIn.rtVal;
                    fnXor: aluOut = exIn.rsVal ^ exIn.rtVal;
                    fnAnd: aluOut = exIn.rsVal & exIn.rtVal;
                    default: aluOut = '0;
                endcase
            end
            opAddi, opLd, opSt: aluOut = exIn.rsVal + exIn.immExt;  // Sum or address
            opLbi:              aluOut = exIn.immExt;
            default:            aluOut = '0;
        endcase
    end

    // Branch on rs against zero
    assign rsZero   = (exIn.rsVal == '0);
    assign taken    = exIn.isJump ||
                      (exIn.isBranch && ((exIn.opcode == opBeqz) ? rsZero : !rsZero));
    assign redirect = exIn.valid && taken;
    assign target   = exIn.pc + dataW'(1) + exIn.immExt;

    always_comb begin
        exOut.valid     = exIn.valid;
        exOut.aluOut    = aluOut;
        exOut.rtVal     = exIn.rtVal;
        exOut.writeAddr = exIn.writeAddr;
        exOut.regWrite  = exIn.regWrite;
        exOut.memRead   = exIn.memRead;
        exOut.memWrite  = exIn.memWrite;
        exOut.halt      = exIn.halt;
    end

endmodule

//--- rtl/fetch.sv
/*
 * Fetch stage. Holds the PC and the instruction memory.
 * With run low the load port fills instruction memory and fetch emits bubbles.
 * With run high the PC steps by one unless stalled, halting or redirected.
 * A redirect from execute reloads the PC and always wins.
 */
`timescale 1ns/100ps

module fetch import procPkg::*; #(
    parameter int imemDepth = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             progWe,
    input  logic [dataW-1:0] progAddr,
    input  logic [dataW-1:0] progData,
    input  logic             stall,
    input  logic             halting,
    input  logic             redirect,
    input  logic [dataW-1:0] target,
    output ifIdT             ifOut
);

    localparam int imemAW = $clog2(imemDepth);

    logic [dataW-1:0] imem [imemDepth];  // Program store, no reset
    logic [dataW-1:0] pc;
    logic             stopped;           // HALT went through decode
    logic             advance;

    assign advance = run && !stall && !halting && !stopped;

    // Load port, only while the core is parked
    always_ff @(posedge clk) begin
        if (!run && progWe) begin
            imem[progAddr[imemAW-1:0]] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            stopped <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= target;                 // Taken branch or jump
            end else if (advance) begin
                pc <= pc + dataW'(1);
            end
            // A HALT flushed by a redirect in the same cycle does not count
            if (halting && !redirect) begin
                stopped <= 1'b1;
            end
        end
    end

    // Combinational read at the PC, bubble when not advancing
    always_comb begin
        ifOut.valid = advance;
        ifOut.pc    = pc;
        ifOut.instr = imem[pc[imemAW-1:0]];
    end

endmodule

//--- rtl/pipeReg.sv
/*
 * Stage register shared by all four pipeline boundaries.
 * payloadT is one of the stage structs and must carry a valid bit.
 * rst or flush turns the entry into a bubble, hold keeps it.
 */
`timescale 1ns/100ps

module pipeReg import procPkg::*; #(
    parameter type payloadT = ifIdT
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    hold,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q.valid <= 1'b0;   // Bubble, flush beats hold
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- rtl/proc.sv
/*
 * Top of the five-stage core. Wires fetch, decode, execute and data memory
 * through four stage registers and closes the writeback loop.
 * Load a program with run low through the prog port, then raise run.
 * retire reports each register write, halted goes high once HALT
 * reaches writeback and stays high until reset.
 */
`timescale 1ns/100ps

module proc import procPkg::*; #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                progWe,
    input  logic [dataW-1:0]    progAddr,
    input  logic [dataW-1:0]    progData,
    output logic                retire,
    output logic [regAddrW-1:0] retireAddr,
    output logic [dataW-1:0]    retireData,
    output logic                halted,
    output logic                err
);

    ifIdT                fetchOut, ifIdQ;
    idExT                decOut, idExQ;
    exMemT               exOut, exMemQ;
    memWbT               memWbD, memWbQ;
    logic                stall, halting, redirect;
    logic [dataW-1:0]    target, memOut, wbData;
    logic                wbEn;
    logic [regAddrW-1:0] wbAddr;
    logic                haltFlag;

    fetch #(.imemDepth(imemDepth)) fetch0 (
        .clk, .rst, .run, .progWe, .progAddr, .progData,
        .stall, .halting, .redirect, .target, .ifOut(fetchOut)
    );

    pipeReg #(.payloadT(ifIdT)) ifId (              // Holds on stall
        .clk, .rst, .hold(stall), .flush(redirect), .d(fetchOut), .q(ifIdQ)
    );

    decode decode0 (
        .clk, .rst, .idIn(ifIdQ), .exPeek(idExQ), .memPeek(exMemQ),
        .wbEn, .wbAddr, .wbData, .idOut(decOut), .stall, .halting, .err
    );

    pipeReg #(.payloadT(idExT)) idEx (              // Decode sends bubbles on stall
        .clk, .rst, .hold(1'b0), .flush(redirect), .d(decOut), .q(idExQ)
    );

    execute execute0 (.exIn(idExQ), .exOut, .redirect, .target);

    pipeReg #(.payloadT(exMemT)) exMem (
        .clk, .rst, .hold(1'b0), .flush(1'b0), .d(exOut), .q(exMemQ)
    );

    dataMem #(.dmemDepth(dmemDepth)) dataMem0 (.clk, .rst, .memIn(exMemQ), .memOut);

    always_comb begin
        memWbD.valid     = exMemQ.valid;
        memWbD.aluOut    = exMemQ.aluOut;
        memWbD.memOut    = memOut;                   // Load data captured here
        memWbD.writeAddr = exMemQ.writeAddr;
        memWbD.regWrite  = exMemQ.regWrite;
        memWbD.memRead   = exMemQ.memRead;
        memWbD.halt      = exMemQ.halt;
    end

    pipeReg #(.payloadT(memWbT)) memWb (
        .clk, .rst, .hold(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
    );

    // Writeback select and register-file port
    assign wbData = memWbQ.memRead ? memWbQ.memOut : memWbQ.aluOut;
    assign wbEn   = memWbQ.valid && memWbQ.regWrite;
    assign wbAddr = memWbQ.writeAddr;

    assign retire     = wbEn;
    assign retireAddr = wbAddr;
    assign retireData = wbData;

    always_ff @(posedge clk) begin
        if (rst) begin
            haltFlag <= 1'b0;
        end else if (memWbQ.valid && memWbQ.halt) begin
            haltFlag <= 1'b1;                        // Sticky until reset
        end
    end

    assign halted = haltFlag || (memWbQ.valid && memWbQ.halt);

endmodule

//--- rtl/procPkg.sv
/*
 * Shared widths, opcodes and stage payloads for the five-stage core.
 * Instruction formats (word addressed, 16 bits):
 *   ALU        op[15:11] rs[10:8] rt[7:5] rd[4:2] funct[1:0]
 *   ADDI/LD/ST op[15:11] rs[10:8] rt[7:5] imm5[4:0]  (LD writes rt, ST stores rt)
 *   LBI        op[15:11] rd[10:8] imm8[7:0]
 *   BEQZ/BNEZ  op[15:11] rs[10:8] imm8[7:0],  J  op[15:11] disp11[10:0]
 * Branch and jump target is pc + 1 + sign-extended offset.
 */
package procPkg;

    localparam int dataW    = 16;    // Data and instruction width
    localparam int regAddrW = 3;     // Eight registers

    typedef enum logic [4:0] {
        opHalt = 5'b00000,
        opNop  = 5'b00001,
        opJ    = 5'b00100,
        opAddi = 5'b01000,
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opSt   = 5'b10000,
        opLd   = 5'b10001,
        opLbi  = 5'b11000,
        opAlu  = 5'b11011    // Register-register, op picked by funct
    } opcodeT;

    typedef enum logic [1:0] {
        fnAdd = 2'b00,
        fnSub = 2'b01,       // rs - rt
        fnXor = 2'b10,
        fnAnd = 2'b11
    } functT;

    typedef struct packed {
        logic             valid;
        logic [dataW-1:0] pc;
        logic [dataW-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic                valid;
        logic [dataW-1:0]    pc;
        opcodeT              opcode;
        functT               funct;
        logic [dataW-1:0]    rsVal;
        logic [dataW-1:0]    rtVal;     // Also store data
        logic [dataW-1:0]    immExt;
        logic [regAddrW-1:0] writeAddr;
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic                isBranch;
        logic                isJump;
        logic                halt;
    } idExT;

    typedef struct packed {
        logic                valid;
        logic [dataW-1:0]    aluOut;    // Result or memory address
        logic [dataW-1:0]    rtVal;
        logic [regAddrW-1:0] writeAddr;
        logic                regWrite;
        logic                memRead;
        logic                memWrite;
        logic                halt;
    } exMemT;

    typedef struct packed {
        logic                valid;
        logic [dataW-1:0]    aluOut;
        logic [dataW-1:0]    memOut;
        logic [regAddrW-1:0] writeAddr;
        logic                regWrite;
        logic                memRead;   // Selects memOut at writeback
        logic                halt;
    } memWbT;

endpackage

//--- tb/procTb.sv
/*
 * Testbench for the five-stage core. Reads programs and expected retire
 * records from tb/progInput.txt, loads each program with run low, then runs
 * it with random run pauses until halted. Checks the retire records in order,
 * the record count, quiet retire after halt and whether err was seen.
 * Failures of the bound properties count toward the result as well.
 */
`timescale 1ns/100ps

module procTb import procPkg::*; ();

    localparam int stimDepth = 1024;

    logic                clk;
    logic                rst;
    logic                run;
    logic                progWe;
    logic [dataW-1:0]    progAddr;
    logic [dataW-1:0]    progData;
    logic                retire;
    logic [regAddrW-1:0] retireAddr;
    logic [dataW-1:0]    retireData;
    logic                halted;
    logic                err;

    logic [dataW-1:0] stim [stimDepth];     // Whole data file
    logic [15:0]      lfsrState;
    logic             limitReady = 1'b0;
    int               limitCycles;
    int               recordErrors;         // Wrong register or value
    int               countErrors;          // Missing or extra records
    int               flagErrors;           // err seen or missed

    proc #(.imemDepth(256), .dmemDepth(256)) dut0 (
        .clk, .rst, .run, .progWe, .progAddr, .progData,
        .retire, .retireAddr, .retireData, .halted, .err
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] randBits(input int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);   // One step per bit
            bits      = {bits[6:0], lfsrState[0]};
        end
        return bits;
    endfunction

    // 40 cycles per program word plus 100 per test
    function automatic int budgetCycles();
        int pos;
        int words;
        int recs;
        int total;
        pos   = 1;
        total = 0;
        for (int t = 0; t < int'(stim[0]); t++) begin
            words = stim[pos];
            recs  = stim[pos + words + 1];
            total += 40 * words + 100;
            pos   += words + 3 + 2 * recs;
        end
        return total;
    endfunction

    task automatic runTest(input int testNum, inout int pos);
        int                  words;
        int                  recBase;
        int                  recs;
        logic                expErr;
        logic                errSeen;
        logic [regAddrW-1:0] expAddr;
        logic [dataW-1:0]    expData;
        logic [regAddrW-1:0] gotAddr [$];
        logic [dataW-1:0]    gotData [$];
        words   = stim[pos];
        recBase = pos + words + 1;
        recs    = stim[recBase];
        expErr  = stim[recBase + 1 + 2 * recs][0];
        rst <= 1'b1;                           // Core parked during reset
        run <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < words; i++) begin
            progWe   <= 1'b1;
            progAddr <= dataW'(i);
            progData <= stim[pos + 1 + i];
            @(posedge clk);
        end
        progWe  <= 1'b0;
        run     <= 1'b1;
        errSeen = 1'b0;
        do begin
            @(posedge clk);
            if (retire) begin
                gotAddr.push_back(retireAddr);
                gotData.push_back(retireData);
            end
            if (err) errSeen = 1'b1;
            run <= (randBits(2) != 8'd0);      // Pause about one cycle in four
        end while (!halted);
        run <= 1'b1;
        repeat (8) begin                       // Pipeline must stay quiet
            @(posedge clk);
            assert (!retire) else begin
                countErrors++;
                $display("Fail t=%0t test %0d: retire after halt r%0d=%h",
                         $time, testNum, retireAddr, retireData);
            end
        end
        assert (gotAddr.size() == recs) else begin
            countErrors++;
            $display("Fail t=%0t test %0d: %0d retire records, expected %0d",
                     $time, testNum, gotAddr.size(), recs);
        end
        for (int i = 0; i < recs && i < gotAddr.size(); i++) begin
            expAddr = stim[recBase + 1 + 2 * i][regAddrW-1:0];
            expData = stim[recBase + 2 + 2 * i];
            assert (gotAddr[i] == expAddr && gotData[i] == expData) else begin
                recordErrors++;
                $display("Fail t=%0t test %0d record %0d: got r%0d=%h, expected r%0d=%h",
                         $time, testNum, i, gotAddr[i], gotData[i], expAddr, expData);
            end
        end
        assert (errSeen == expErr) else begin
            flagErrors++;
            $display("Fail t=%0t test %0d: err seen %0b, expected %0b",
                     $time, testNum, errSeen, expErr);
        end
        pos = recBase + 2 + 2 * recs;          // Start of the next test
    endtask

    initial begin
        int pos;
        rst          = 1'b1;
        run          = 1'b0;
        progWe       = 1'b0;
        progAddr     = '0;
        progData     = '0;
        recordErrors = 0;
        countErrors  = 0;
        flagErrors   = 0;
        lfsrState    = 16'd899;
        $readmemh("tb/progInput.txt", stim);
        if ($isunknown(stim[0])) begin
            $display("Could not read the stimulus file tb/progInput.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            limitCycles = budgetCycles();
            limitReady  = 1'b1;
            pos         = 1;
            for (int t = 0; t < int'(stim[0]); t++) begin
                runTest(t, pos);
            end
            $display("Errors: %0d record, %0d count, %0d err flag, %0d property",
                     recordErrors, countErrors, flagErrors, dut0.props0.failCount);
            if (recordErrors + countErrors + flagErrors + dut0.props0.failCount == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

    // Watchdog starts once the file has set the budget
    initial begin
        wait (limitReady);
        repeat (limitCycles) @(posedge clk);
        $display("Timeout: tests still running after %0d cycles", limitCycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- tb/proc_props.sv
/*
 * Concurrent checks on the core outputs, bound into proc.
 * Covers quiet outputs after reset, sticky halted and no retire after halt.
 * failCount tallies failed checks for the testbench summary line.
 */
`timescale 1ns/100ps

module procProps (
    input logic clk,
    input logic rst,
    input logic retire,
    input logic halted
);

    int failCount = 0;    // Failed checks so far

    // Reset leaves every stage register holding a bubble
    assert property (@(posedge clk) rst |=> !retire && !halted)
        else begin
            $error("retire or halted high in the cycle after reset");
            failCount++;
        end

    // Only a reset clears the sticky flag
    assert property (@(posedge clk) disable iff (rst) $fell(halted) |-> $past(rst))
        else begin
            $error("halted fell without a reset");
            failCount++;
        end

    // Nothing behind HALT may write a register
    assert property (@(posedge clk) disable iff (rst) halted |-> !retire)
        else begin
            $error("retire pulsed while halted was high");
            failCount++;
        end

endmodule

bind proc procProps props0 (.clk, .rst, .retire, .halted);

//--- tb/progInput.txt
// Hex words. First the test count, then per test: program word count, program words,
// retire record count, records as register/value pairs, expected err flag
6
// ALU ops, ADDI and LBI with 16-bit wraparound
9  C17F C285 D94C D951 D956 D95B 42FF 410F 0000
8  1 007F 2 FF85 3 0004 4 00FA 5 FFFA 6 0005 7 FF84 0 008E
0
// Back-to-back dependent chain through the interlock
8  C101 D924 D924 4143 DA2D DB42 D810 0000
7  1 0001 1 0002 1 0004 2 0007 3 0003 0 0004 4 0008
0
// Store then load, load from an unwritten word, load-use
9  C110 C2AB 8142 8962 8985 43A1 80BF 88DF 0000
6  1 0010 2 FFAB 3 FFAB 4 0000 5 FFAC 6 FFAC
0
// Taken BEQZ, BNEZ and J skip two words, not-taken branches fall through
10 C100 6102 C211 C322 C433 6C02 C244 C355 6901 C566 2002 C677 0000 6401 C788 0000
4  1 0000 4 0033 5 0066 7 FF88
0
// HALT stops everything behind it
5  C112 4141 0000 C334 C456
2  1 0012 2 0013
0
// Unused opcode 11111 raises err and acts as a no-op
5  C103 F800 4144 0800 0000
2  1 0003 2 0007
1
